//--- all.f
+incdir+dv
source/shuffle_pkg.sv
source/load_tracker.sv
source/shuffle_stage.sv
source/cluster_fanout.sv
source/shuffle_top.sv
dv/tb_shuffle_top.sv

//--- dv/shuffle_model.svh
// Reference model for the read shuffle network testbench
// Derives the stage enables of a load command and applies the block
// swaps of every enabled stage in chain order to a full beat
`ifndef SHUFFLE_MODEL_SVH
`define SHUFFLE_MODEL_SVH

// Stages from 3 + vew upward are active
// Mask loads use all of them
function automatic logic [NumStages-1:0] stage_enables(input load_cmd_t cmd);
  logic [NumStages-1:0] ones;
  ones = '1;
  if (cmd.mask) begin
    return ones;
  end
  return ones << (3 + int'(cmd.vew));
endfunction

// One stage worked out bit by bit
function automatic logic [TotalDataWidth-1:0] swap_blocks(
  input logic [TotalDataWidth-1:0] word,
  input int                        scale
);
  logic [TotalDataWidth-1:0] res;
  int bsize;
  int blk;
  int grp;
  int pos;
  int src;
  bsize = NrLanes << scale;
  for (int b = 0; b < TotalDataWidth; b++) begin
    blk = b / bsize;
    grp = blk / (2 * NrClusters);
    pos = blk % (2 * NrClusters);
    // Position 2i+j of a group reads block j*NrClusters+i of that group
    src = grp * 2 * NrClusters + (pos % 2) * NrClusters + pos / 2;
    res[b] = word[src * bsize + b % bsize];
  end
  return res;
endfunction

// Whole chain with the smallest blocks first
function automatic logic [TotalDataWidth-1:0] shuffle_beat(
  input logic [TotalDataWidth-1:0] word,
  input logic [NumStages-1:0]      en
);
  logic [TotalDataWidth-1:0] res;
  res = word;
  for (int s = 0; s < NumStages; s++) begin
    if (en[s]) begin
      res = swap_blocks(res, s);
    end
  end
  return res;
endfunction

`endif

//--- dv/tb_shuffle_top.sv
// Testbench for the read shuffle network
// Random load commands and beats, random cluster back-pressure and a
// queue of expected beats checked slice by slice on every cluster
`timescale 1ns/1ps

module tb_shuffle_top import shuffle_pkg::*; ();

  localparam int WaitLimit = 400;

  logic                                        clk_i = 1'b0;
  logic                                        rst_ni;
  logic                                        cmd_valid_i;
  logic                                        cmd_ready_o;
  load_cmd_t                                   cmd_i;
  logic                                        mem_valid_i;
  logic                                        mem_ready_o;
  beat_u                                       mem_data_i;
  logic [NrClusters-1:0]                       cl_valid_o;
  logic [NrClusters-1:0]                       cl_ready_i;
  logic [NrClusters-1:0][ClusterDataWidth-1:0] cl_data_o;
  logic [NrClusters-1:0]                       cl_last_o;

  // Expected beats as {last, shuffled data}, each cluster reads at its own index
  logic [TotalDataWidth:0] exp_beats [$];
  int                      cl_idx [NrClusters];
  load_cmd_t               pend_q [$];
  logic                    random_ready;
  int                      cycle = 0;
  int                      fire_cycle;

  `include "shuffle_model.svh"

  shuffle_top DUT (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // Cluster back-pressure
  always @(negedge clk_i) begin
    cl_ready_i <= random_ready ? NrClusters'($urandom) : '1;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  function automatic load_cmd_t random_cmd();
    load_cmd_t cmd;
    cmd.vew    = vew_e'($urandom_range(2));
    cmd.mask   = ($urandom_range(3) == 0);
    cmd.nbeats = BeatCntWidth'($urandom_range(6, 1));
    return cmd;
  endfunction

  function automatic bit all_delivered();
    for (int c = 0; c < NrClusters; c++) begin
      if (cl_idx[c] != exp_beats.size()) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  ////////////////////
  // Drivers
  ////////////////////

  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic send_cmd(input load_cmd_t cmd);
    int waited;
    waited      = 0;
    cmd_valid_i = 1'b1;
    cmd_i       = cmd;
    #1;
    while (!cmd_ready_o) begin
      waited++;
      assert (waited < WaitLimit) else report_failure("command was never accepted");
      @(negedge clk_i);
      #1;
    end
    pend_q.push_back(cmd);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic send_beat(input load_cmd_t cmd, input logic is_last);
    beat_u data;
    int    waited;
    waited      = 0;
    data.flat   = {$urandom, $urandom, $urandom, $urandom};
    mem_valid_i = 1'b1;
    mem_data_i  = data;
    #1;
    while (!mem_ready_o) begin
      waited++;
      assert (waited < WaitLimit) else report_failure("memory beat was never accepted");
      @(negedge clk_i);
      #1;
    end
    exp_beats.push_back({is_last, shuffle_beat(data.flat, stage_enables(cmd))});
    fire_cycle = cycle;
    @(negedge clk_i);
    mem_valid_i = 1'b0;
  endtask

  // Beats for the oldest queued commands, with random idle cycles
  task automatic run_beats(input int n_cmds);
    load_cmd_t cmd;
    for (int k = 0; k < n_cmds; k++) begin
      cmd = pend_q.pop_front();
      for (int b = 0; b < int'(cmd.nbeats); b++) begin
        if ($urandom_range(3) == 0) begin
          @(negedge clk_i);
        end
        send_beat(cmd, b == int'(cmd.nbeats) - 1);
      end
    end
  endtask

  // Checked at the falling edge, before the monitor updates its indices
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!all_delivered()) begin
      waited++;
      assert (waited < WaitLimit) else report_failure("clusters did not receive all beats");
      @(negedge clk_i);
    end
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  always @(negedge clk_i) begin : check_outputs
    logic [TotalDataWidth:0] exp_word;
    #1;
    if (rst_ni) begin
      for (int c = 0; c < NrClusters; c++) begin
        if (cl_valid_o[c] && cl_ready_i[c]) begin
          assert (cl_idx[c] < exp_beats.size()) else
            report_failure($sformatf("cluster %0d took a slice that was never sent", c));
          exp_word = exp_beats[cl_idx[c]];
          assert (cl_data_o[c] === exp_word[c*ClusterDataWidth +: ClusterDataWidth]) else
            report_failure($sformatf("error: cl_data_o[%0d] = %h, expected %h", c,
              cl_data_o[c], exp_word[c*ClusterDataWidth +: ClusterDataWidth]));
          assert (cl_last_o[c] === exp_word[TotalDataWidth]) else
            report_failure($sformatf("error: cl_last_o[%0d] = %h, expected %h", c,
              cl_last_o[c], exp_word[TotalDataWidth]));
          cl_idx[c]++;
        end
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : stimulus
    load_cmd_t cmd;
    int        waited;
    void'($urandom(32'h9b32));
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_i        = '0;
    mem_valid_i  = 1'b0;
    mem_data_i   = '0;
    cl_ready_i   = '1;
    random_ready = 1'b0;
    for (int c = 0; c < NrClusters; c++) begin
      cl_idx[c] = 0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    assert (cmd_ready_o === 1'b1) else
      report_failure($sformatf("error: cmd_ready_o = %h, expected 1", cmd_ready_o));
    assert (mem_ready_o === 1'b0) else
      report_failure($sformatf("error: mem_ready_o = %h, expected 0", mem_ready_o));
    assert (cl_valid_o === '0) else
      report_failure($sformatf("error: cl_valid_o = %h, expected 0", cl_valid_o));
    @(negedge clk_i);

    // Each element width, then a mask load
    for (int w = 0; w < 4; w++) begin
      cmd.vew    = (w == 3) ? E8 : vew_e'(w);
      cmd.mask   = (w == 3);
      cmd.nbeats = 3;
      send_cmd(cmd);
      run_beats(1);
    end
    wait_drained();

    // Latency of a lone beat with every cluster ready
    @(negedge clk_i);
    cmd.vew    = E32;
    cmd.mask   = 1'b0;
    cmd.nbeats = 1;
    send_cmd(cmd);
    run_beats(1);
    waited = 0;
    #1;
    while (!cl_valid_o[0]) begin
      waited++;
      assert (waited < WaitLimit) else report_failure("beat never reached cluster 0");
      @(negedge clk_i);
      #1;
    end
    assert (cycle - fire_cycle == NumStages) else
      report_failure($sformatf("error: latency = %h, expected %h", cycle - fire_cycle,
        NumStages));
    @(negedge clk_i);
    wait_drained();

    // Random commands under back-pressure
    random_ready = 1'b1;
    repeat (40) begin
      send_cmd(random_cmd());
      if ($urandom_range(1) == 0) begin
        send_cmd(random_cmd());
      end
      run_beats(pend_q.size());
    end
    wait_drained();

    // Fill the command FIFO, then retire one command to free a slot
    for (int k = 0; k < NumTrackers; k++) begin
      send_cmd(random_cmd());
    end
    #1;
    assert (cmd_ready_o === 1'b0) else
      report_failure($sformatf("error: cmd_ready_o = %h, expected 0", cmd_ready_o));
    @(negedge clk_i);
    run_beats(1);
    #1;
    assert (cmd_ready_o === 1'b1) else
      report_failure($sformatf("error: cmd_ready_o = %h, expected 1", cmd_ready_o));
    @(negedge clk_i);
    send_cmd(random_cmd());
    run_beats(pend_q.size());
    wait_drained();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- source/shuffle_top.sv
// Read-data shuffle network, top level
// Load tracker, a chain of NumStages registered shuffle stages and the
// per-cluster fan-out. A beat reaches the clusters NumStages cycles
// after it is taken from memory when nothing stalls.
`timescale 1ns/1ps

module shuffle_top import shuffle_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  // Load commands
  input  logic                                   cmd_valid_i,
  output logic                                   cmd_ready_o,
  input  load_cmd_t                              cmd_i,

  // Memory read beats
  input  logic                                   mem_valid_i,
  output logic                                   mem_ready_o,
  input  beat_u                                  mem_data_i,

  // Clusters
  output logic [NrClusters-1:0]                  cl_valid_o,
  input  logic [NrClusters-1:0]                  cl_ready_i,
  output logic [NrClusters-1:0][ClusterDataWidth-1:0] cl_data_o,
  output logic [NrClusters-1:0]                  cl_last_o
);

  // Link 0 leaves the tracker, link s+1 leaves stage s
  logic        [NumStages:0] link_valid;
  logic        [NumStages:0] link_ready;
  stage_beat_t [NumStages:0] link_beat;

  ////////////////////
  // Tracker
  ////////////////////

  load_tracker i_load_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .mem_valid_i (mem_valid_i),
    .mem_ready_o (mem_ready_o),
    .mem_data_i  (mem_data_i),
    .out_valid_o (link_valid[0]),
    .out_ready_i (link_ready[0]),
    .out_beat_o  (link_beat[0])
  );

  ////////////////////
  // Stage chain
  ////////////////////

  // Block size doubles from one stage to the next
  for (genvar s = 0; s < NumStages; s++) begin : g_stage
    shuffle_stage #(
      .Scale (s)
    ) i_shuffle_stage (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .in_valid_i  (link_valid[s]),
      .in_ready_o  (link_ready[s]),
      .in_beat_i   (link_beat[s]),
      .out_valid_o (link_valid[s+1]),
      .out_ready_i (link_ready[s+1]),
      .out_beat_o  (link_beat[s+1])
    );
  end

  ////////////////////
  // Fan-out
  ////////////////////

  cluster_fanout i_cluster_fanout (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (link_valid[NumStages]),
    .in_ready_o (link_ready[NumStages]),
    .in_beat_i  (link_beat[NumStages]),
    .cl_valid_o (cl_valid_o),
    .cl_ready_i (cl_ready_i),
    .cl_data_o  (cl_data_o),
    .cl_last_o  (cl_last_o)
  );

endmodule

//--- source/cluster_fanout.sv
// Per-cluster fan-out of the shuffled beat
// Every cluster gets its own slice with its own valid/ready pair.
// Clusters that already took their slice are masked off until the
// slowest one is done, then the beat retires upstream.
`timescale 1ns/1ps

module cluster_fanout import shuffle_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  // From the last shuffle stage
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  input  stage_beat_t                            in_beat_i,

  // Cluster side
  output logic [NrClusters-1:0]                  cl_valid_o,
  input  logic [NrClusters-1:0]                  cl_ready_i,
  output logic [NrClusters-1:0][ClusterDataWidth-1:0] cl_data_o,
  output logic [NrClusters-1:0]                  cl_last_o
);

  // Set once a cluster has taken the current slice
  logic [NrClusters-1:0] taken_q, taken_d;
  logic [NrClusters-1:0] cl_fire;

  ////////////////////
  // Cluster outputs
  ////////////////////

  assign cl_valid_o = {NrClusters{in_valid_i}} & ~taken_q;
  assign cl_fire    = cl_valid_o & cl_ready_i;

  // Slice c of the beat belongs to cluster c after the last stage
  always_comb begin
    for (int c = 0; c < NrClusters; c++) begin
      cl_data_o[c] = in_beat_i.data.cluster[c];
      cl_last_o[c] = in_beat_i.last;
    end
  end

  ////////////////////
  // Retire logic
  ////////////////////

  // Done once each cluster has either taken its slice earlier or takes it now
  assign in_ready_o = &(taken_q | cl_ready_i);

  always_comb begin
    taken_d = taken_q;
    if (in_valid_i) begin
      if (in_ready_o) begin
        // Beat leaves, next one starts fresh
        taken_d = '0;
      end else begin
        taken_d = taken_q | cl_fire;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= '0;
    end else begin
      taken_q <= taken_d;
    end
  end

  // A slice handed over while others still stall is not offered again
  for (genvar c = 0; c < NrClusters; c++) begin : g_once
    a_no_repeat: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cl_fire[c] && !in_ready_o |=> !cl_valid_o[c]);
  end

endmodule

//--- source/shuffle_stage.sv
// One stage of the read shuffle chain
// Swaps blocks of NrLanes << Scale bits inside groups of 2*NrClusters
// blocks when the beat's enable bit for this stage is set, then holds
// the result in a single-entry valid/ready register.
`timescale 1ns/1ps

module shuffle_stage import shuffle_pkg::*; #(
  parameter int unsigned Scale = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  stage_beat_t in_beat_i,

  output logic        out_valid_o,
  input  logic        out_ready_i,
  output stage_beat_t out_beat_o
);

  // Block and group geometry of this stage
  localparam int unsigned BlockSize   = NrLanes << Scale;
  localparam int unsigned GroupBlocks = 2 * NrClusters;
  localparam int unsigned NumGroups   = TotalDataWidth / (BlockSize * GroupBlocks);

  stage_beat_t perm_beat;
  stage_beat_t beat_q;
  logic        valid_q;

  ////////////////////
  // Block permutation
  ////////////////////

  // Output block 2i+j of a group takes input block j*NrClusters+i
  // Blocks of even index gather towards the low clusters
  always_comb begin
    perm_beat = in_beat_i;
    if (in_beat_i.shuffle_en[Scale]) begin
      for (int unsigned k = 0; k < NumGroups; k++) begin
        for (int unsigned i = 0; i < NrClusters; i++) begin
          for (int unsigned j = 0; j < 2; j++) begin
            perm_beat.data.flat[(k*GroupBlocks + 2*i + j)*BlockSize +: BlockSize] =
              in_beat_i.data.flat[(k*GroupBlocks + j*NrClusters + i)*BlockSize +: BlockSize];
          end
        end
      end
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // Accept while empty or while the current beat leaves
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      beat_q <= perm_beat;
    end
  end

  assign out_valid_o = valid_q;
  assign out_beat_o  = beat_q;

  // Stalled beats stay put until the next stage takes them
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o));

endmodule

//--- source/load_tracker.sv
// Load command tracker
// Queues load commands in a small circular FIFO and tags every memory
// beat with the stage enables of the head command. The beat that uses
// up the head command's beat count is marked last and retires it.
`timescale 1ns/1ps

module load_tracker import shuffle_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Load commands
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  load_cmd_t   cmd_i,

  // Memory read beats
  input  logic        mem_valid_i,
  output logic        mem_ready_o,
  input  beat_u       mem_data_i,

  // Towards stage 0
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output stage_beat_t out_beat_o
);

  localparam int unsigned PtrWidth = $clog2(NumTrackers);
  localparam int unsigned CntWidth = $clog2(NumTrackers + 1);

  // Command storage
  // The head entry is rewritten with its remaining beats
  load_cmd_t [NumTrackers-1:0] cmd_mem_q;

  logic [PtrWidth-1:0] wr_ptr_q, wr_ptr_d;
  logic [PtrWidth-1:0] rd_ptr_q, rd_ptr_d;
  logic [CntWidth-1:0] cnt_q, cnt_d;

  load_cmd_t            head_cmd;
  logic                 fifo_empty;
  logic                 push;
  logic                 beat_fire;
  logic                 head_last;
  logic                 pop;
  logic [NumStages-1:0] stage_en;

  assign head_cmd   = cmd_mem_q[rd_ptr_q];
  assign fifo_empty = (cnt_q == '0);

  ////////////////////
  // Handshakes
  ////////////////////

  assign cmd_ready_o = (cnt_q != NumTrackers);
  assign push        = cmd_valid_i && cmd_ready_o;

  // Beats only flow while a command is there to describe them
  assign mem_ready_o = !fifo_empty && out_ready_i;
  assign out_valid_o = mem_valid_i && !fifo_empty;
  assign beat_fire   = mem_valid_i && mem_ready_o;

  // A zero count behaves like a single beat
  assign head_last = (head_cmd.nbeats <= 1);
  assign pop       = beat_fire && head_last;

  ////////////////////
  // Stage enables
  ////////////////////

  // Stage 3 swaps blocks of NrLanes bytes, so byte elements start there
  // Wider elements skip one more stage per doubling
  // Mask loads need every stage down to single bits
  always_comb begin
    for (int s = 0; s < NumStages; s++) begin
      stage_en[s] = head_cmd.mask || (s >= 3 + int'(head_cmd.vew));
    end
  end

  assign out_beat_o.data       = mem_data_i;
  assign out_beat_o.shuffle_en = stage_en;
  assign out_beat_o.last       = head_last;

  ////////////////////
  // FIFO pointers
  ////////////////////

  always_comb begin
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    cnt_d    = cnt_q;

    if (push) begin
      wr_ptr_d = (wr_ptr_q == PtrWidth'(NumTrackers - 1)) ? '0 : wr_ptr_q + 1'b1;
    end
    if (pop) begin
      rd_ptr_d = (rd_ptr_q == PtrWidth'(NumTrackers - 1)) ? '0 : rd_ptr_q + 1'b1;
    end

    // Simultaneous push and pop keep the fill level
    if (push && !pop) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop && !push) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Push and beat never hit the same entry since the FIFO is neither
  // empty on a beat nor full on a push
  always_ff @(posedge clk_i) begin
    if (push) begin
      cmd_mem_q[wr_ptr_q] <= cmd_i;
    end
    if (beat_fire) begin
      cmd_mem_q[rd_ptr_q].nbeats <= head_cmd.nbeats - 1'b1;
    end
  end

  // Every beat handed to stage 0 belongs to a queued command
  // The pointers differ, or they meet with the FIFO full
  a_beat_has_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && out_ready_i |-> (wr_ptr_q != rd_ptr_q) || (cnt_q == NumTrackers));

endmodule

//--- source/shuffle_pkg.sv
// Shared definitions for the read-data shuffle network
// Holds the cluster geometry, the element-width encoding, the beat word
// and the stream payloads that run between tracker, stages and fan-out
package shuffle_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // Lanes inside one cluster
  localparam int unsigned NrLanes = 2;

  // Clusters fed from one memory port
  localparam int unsigned NrClusters = 2;

  // Slice of the beat that belongs to one cluster
  localparam int unsigned ClusterDataWidth = 64;

  // Full memory beat
  localparam int unsigned TotalDataWidth = NrClusters * ClusterDataWidth;

  // Block size doubles per stage, starting at NrLanes bits for mask loads
  // and ending below one cluster slice
  localparam int unsigned NumStages = $clog2(ClusterDataWidth / NrLanes);

  // Depth of the load command FIFO
  localparam int unsigned NumTrackers = 4;

  // Beats per load command
  localparam int unsigned BeatCntWidth = 8;

  ////////////////////
  // Element width
  ////////////////////

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    E8  = 2'd0,
    E16 = 2'd1,
    E32 = 2'd2
  } vew_e;

  ////////////////////
  // Beat word
  ////////////////////

  // Stages permute the flat view
  // The fan-out reads one slice per cluster
  typedef union packed {
    logic [TotalDataWidth-1:0]                   flat;
    logic [NrClusters-1:0][ClusterDataWidth-1:0] cluster;
  } beat_u;

  ////////////////////
  // Stream payloads
  ////////////////////

  // Load command as issued by the vector load unit
  typedef struct packed {
    vew_e                    vew;
    // 1-bit elements, all stages active
    logic                    mask;
    // Number of memory beats in this load
    logic [BeatCntWidth-1:0] nbeats;
  } load_cmd_t;

  // Beat moving through the stage chain
  // Each stage looks only at its own enable bit
  typedef struct packed {
    beat_u                 data;
    logic [NumStages-1:0]  shuffle_en;
    // Final beat of the owning load command
    logic                  last;
  } stage_beat_t;

endpackage
